// ==== logic/linebuf_pkg.sv ====
package linebuf_pkg;

  localparam int lwidth  = 8;
  localparam int dwidth  = 16;
  localparam int max_fil = 5;
  localparam int max_img = 32;
  localparam int max_pad = (max_fil - 1) / 2;

  // a line holds one image row plus both padding margins
  localparam int buf_size = max_img + 2 * max_pad;
  // one spare line so the row being written is never read
  localparam int buf_line = max_fil + 1;

  localparam int size_width = $clog2(buf_size);
  localparam int line_width = $clog2(buf_line) + 1;

  typedef logic [lwidth-1:0]     len_t;
  typedef logic [dwidth-1:0]     pixel_t;
  typedef logic [size_width-1:0] addr_t;
  typedef logic [line_width-1:0] sel_t;   // 0 selects no line

  typedef enum logic [1:0] {
    s_wait,
    s_charge,
    s_active
  } ctrl_state_t;

endpackage

// ==== logic/line_mem.sv ====
module line_mem (
  input  logic                clk,
  input  logic                we,
  input  linebuf_pkg::addr_t  addr,
  input  linebuf_pkg::pixel_t wdata,
  output linebuf_pkg::pixel_t rdata
);

  linebuf_pkg::pixel_t mem [linebuf_pkg::buf_size];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];   // registered read, old data on a same-address write
  end

endmodule

// ==== logic/linebuf_ctrl.sv ====
module linebuf_ctrl (
  input  logic               clk,
  input  logic               xrst,
  input  linebuf_pkg::len_t  img_size,
  input  linebuf_pkg::len_t  fil_size,
  input  linebuf_pkg::len_t  pad_size,
  input  logic               buf_req,
  output logic               buf_ack,
  output logic               buf_ready,
  output logic               buf_start,
  output logic               buf_valid,
  output logic               buf_stop,
  output logic               buf_wcol,
  output logic               buf_rrow [linebuf_pkg::max_fil],
  output linebuf_pkg::sel_t  buf_wsel,
  output linebuf_pkg::sel_t  buf_rsel,
  output logic               buf_we,
  output linebuf_pkg::addr_t buf_addr
);

  linebuf_pkg::ctrl_state_t state;

  linebuf_pkg::addr_t col_count;
  linebuf_pkg::addr_t row_count;
  linebuf_pkg::sel_t  mem_count;

  linebuf_pkg::len_t  pad_both;
  linebuf_pkg::len_t  col_last;
  logic               row_end;
  logic               charge_end;
  logic               active_end;
  logic               active;

  logic               start_now;
  logic               valid_now;
  logic               stop_now;

  logic [2:0]         ack_dly;
  logic [2:0]         start_dly;
  logic [2:0]         valid_dly;
  logic [2:0]         stop_dly;

  linebuf_pkg::sel_t  rsel_d0;
  linebuf_pkg::sel_t  rsel_d1;
  logic               rrow_d0 [linebuf_pkg::max_fil];
  logic               rrow_d1 [linebuf_pkg::max_fil];

  assign pad_both = pad_size << 1;
  assign col_last = img_size + pad_both - 1;   // last column of a padded row
  assign active   = state == linebuf_pkg::s_active;

  assign row_end    = col_count == col_last;
  assign charge_end = row_end && mem_count == fil_size - pad_size - 1;
  assign active_end = row_end && row_count == img_size + pad_size;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= linebuf_pkg::s_wait;
    end else begin
      case (state)
        linebuf_pkg::s_wait: begin
          if (buf_req && buf_ack) begin
            state <= linebuf_pkg::s_charge;
          end
        end
        linebuf_pkg::s_charge: begin
          if (charge_end) begin
            state <= linebuf_pkg::s_active;
          end
        end
        linebuf_pkg::s_active: begin
          if (active_end) begin
            state <= linebuf_pkg::s_wait;
          end
        end
        default: begin
          state <= linebuf_pkg::s_wait;
        end
      endcase
    end
  end

  // ack only after the write and read pipes have drained
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack_dly <= '0;
    end else begin
      ack_dly <= {ack_dly[1:0], state == linebuf_pkg::s_wait};
    end
  end

  assign buf_ack = state == linebuf_pkg::s_wait && ack_dly[2];

  always_ff @(posedge clk) begin
    if (!xrst || state == linebuf_pkg::s_wait) begin
      col_count <= '0;
      row_count <= '0;
      mem_count <= '0;
    end else if (row_end) begin
      col_count <= '0;
      row_count <= row_count + 1'b1;
      if (mem_count == fil_size) begin   // ring of fil_size+1 lines
        mem_count <= '0;
      end else begin
        mem_count <= mem_count + 1'b1;
      end
    end else begin
      col_count <= col_count + 1'b1;
    end
  end

  // row_count counts image rows, the top padding rows are never stored
  assign buf_ready = state != linebuf_pkg::s_wait
                     && row_count < img_size
                     && col_count >= pad_size
                     && col_count < img_size + pad_size;

  always_ff @(posedge clk) begin
    if (!xrst || state == linebuf_pkg::s_wait) begin
      buf_wcol <= 1'b0;
      buf_we   <= 1'b0;
      buf_wsel <= '0;
      buf_addr <= '0;
    end else begin
      buf_wcol <= buf_ready;
      buf_we   <= row_count < img_size + pad_size;
      buf_wsel <= mem_count + 1'b1;
      buf_addr <= col_count;
    end
  end

  // the window for counter row r starts at line (r+1) mod (fil_size+1)
  always_ff @(posedge clk) begin
    if (!xrst || state == linebuf_pkg::s_wait) begin
      rsel_d0 <= '0;
    end else if (active && col_count == '0) begin
      if (rsel_d0 == '0) begin
        rsel_d0 <= pad_size == '0
                   ? linebuf_pkg::sel_t'(1)
                   : linebuf_pkg::sel_t'(fil_size - pad_size + 2);
      end else if (rsel_d0 == fil_size + 1) begin
        rsel_d0 <= linebuf_pkg::sel_t'(1);
      end else begin
        rsel_d0 <= rsel_d0 + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rsel_d1 <= '0;
    end else begin
      rsel_d1 <= rsel_d0;
    end
  end

  assign buf_rsel = rsel_d1;

  for (genvar j = 0; j < linebuf_pkg::max_fil; j++) begin : g_rrow
    always_ff @(posedge clk) begin
      if (!xrst) begin
        rrow_d0[j] <= 1'b0;
        rrow_d1[j] <= 1'b0;
      end else begin
        rrow_d0[j] <= j < fil_size
                      && fil_size <= row_count + j
                      && row_count + j < img_size + fil_size;   // image row r-fil+j exists
        rrow_d1[j] <= rrow_d0[j];
      end
    end

    assign buf_rrow[j] = rrow_d1[j];
  end

  assign start_now = active && row_count == fil_size - pad_size && col_count == fil_size - 1;
  assign valid_now = active && col_count >= fil_size - 1;
  assign stop_now  = active && active_end;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start_dly <= '0;
      valid_dly <= '0;
      stop_dly  <= '0;
    end else begin
      start_dly <= {start_dly[1:0], start_now};
      valid_dly <= {valid_dly[1:0], valid_now};
      stop_dly  <= {stop_dly[1:0], stop_now};
    end
  end

  assign buf_start = start_dly[2];
  assign buf_valid = valid_dly[2];
  assign buf_stop  = stop_dly[2];

endmodule

// ==== logic/linebuf_bank.sv ====
module linebuf_bank (
  input  logic                clk,
  input  logic                xrst,
  input  linebuf_pkg::pixel_t pix_data,
  input  logic                buf_wcol,
  input  logic                buf_we,
  input  linebuf_pkg::addr_t  buf_addr,
  input  linebuf_pkg::sel_t   buf_wsel,
  input  linebuf_pkg::sel_t   buf_rsel,
  input  logic                buf_rrow [linebuf_pkg::max_fil],
  input  linebuf_pkg::len_t   fil_size,
  output linebuf_pkg::pixel_t col_data [linebuf_pkg::max_fil]
);

  linebuf_pkg::pixel_t              pix_hold;
  linebuf_pkg::pixel_t              wdata;
  logic [linebuf_pkg::buf_line-1:0] mem_we;
  linebuf_pkg::pixel_t              rdata [linebuf_pkg::buf_line];
  linebuf_pkg::pixel_t              col_next [linebuf_pkg::max_fil];

  // buf_wcol lags pix_ready by one cycle, so the pixel is held one cycle too
  always_ff @(posedge clk) begin
    pix_hold <= pix_data;
  end

  assign wdata = buf_wcol ? pix_hold : '0;   // zeros form the side padding

  for (genvar k = 0; k < linebuf_pkg::buf_line; k++) begin : g_line
    assign mem_we[k] = buf_we && buf_wsel == linebuf_pkg::sel_t'(k + 1);

    line_mem u_line_mem (
      .clk   (clk),
      .we    (mem_we[k]),
      .addr  (buf_addr),
      .wdata (wdata),
      .rdata (rdata[k])
    );
  end

  // window row j comes from ring line (rsel-1+j) mod (fil_size+1)
  always_comb begin
    int ring;
    int base;
    int idx;
    ring = int'(fil_size) + 1;
    base = int'(buf_rsel) - 1;
    for (int j = 0; j < linebuf_pkg::max_fil; j++) begin
      idx = base + j;
      if (idx >= ring) begin
        idx = idx - ring;
      end
      if (buf_rsel != '0 && buf_rrow[j] && idx >= 0 && idx < linebuf_pkg::buf_line) begin
        col_next[j] = rdata[idx];
      end else begin
        col_next[j] = '0;   // top and bottom padding rows
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_data <= '{default: '0};
    end else begin
      col_data <= col_next;
    end
  end

endmodule

// ==== logic/window_shift.sv ====
module window_shift (
  input  logic                clk,
  input  logic                xrst,
  input  linebuf_pkg::pixel_t col_data [linebuf_pkg::max_fil],
  input  logic                buf_start,
  input  logic                buf_valid,
  input  logic                buf_stop,
  output linebuf_pkg::pixel_t win_data [linebuf_pkg::max_fil][linebuf_pkg::max_fil],
  output logic                win_start,
  output logic                win_valid,
  output logic                win_stop
);

  // win_data[row][col], newest column enters at col max_fil-1
  always_ff @(posedge clk) begin
    for (int i = 0; i < linebuf_pkg::max_fil; i++) begin
      for (int k = 0; k < linebuf_pkg::max_fil - 1; k++) begin
        win_data[i][k] <= win_data[i][k+1];
      end
      win_data[i][linebuf_pkg::max_fil-1] <= col_data[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_start <= 1'b0;
      win_valid <= 1'b0;
      win_stop  <= 1'b0;
    end else begin
      win_start <= buf_start;
      win_valid <= buf_valid;
      win_stop  <= buf_stop;
    end
  end

endmodule

// ==== logic/linebuf_top.sv ====
module linebuf_top (
  input  logic                clk,
  input  logic                xrst,
  input  linebuf_pkg::len_t   img_size,
  input  linebuf_pkg::len_t   fil_size,
  input  linebuf_pkg::len_t   pad_size,
  input  logic                buf_req,
  output logic                buf_ack,
  output logic                pix_ready,
  input  linebuf_pkg::pixel_t pix_data,
  output logic                win_start,
  output logic                win_valid,
  output logic                win_stop,
  output linebuf_pkg::pixel_t win_data [linebuf_pkg::max_fil][linebuf_pkg::max_fil]
);

  logic                buf_start;
  logic                buf_valid;
  logic                buf_stop;
  logic                buf_wcol;
  logic                buf_we;
  linebuf_pkg::addr_t  buf_addr;
  linebuf_pkg::sel_t   buf_wsel;
  linebuf_pkg::sel_t   buf_rsel;
  logic                buf_rrow [linebuf_pkg::max_fil];
  linebuf_pkg::pixel_t col_data [linebuf_pkg::max_fil];

  linebuf_ctrl u_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .img_size  (img_size),
    .fil_size  (fil_size),
    .pad_size  (pad_size),
    .buf_req   (buf_req),
    .buf_ack   (buf_ack),
    .buf_ready (pix_ready),
    .buf_start (buf_start),
    .buf_valid (buf_valid),
    .buf_stop  (buf_stop),
    .buf_wcol  (buf_wcol),
    .buf_rrow  (buf_rrow),
    .buf_wsel  (buf_wsel),
    .buf_rsel  (buf_rsel),
    .buf_we    (buf_we),
    .buf_addr  (buf_addr)
  );

  linebuf_bank u_bank (
    .clk      (clk),
    .xrst     (xrst),
    .pix_data (pix_data),
    .buf_wcol (buf_wcol),
    .buf_we   (buf_we),
    .buf_addr (buf_addr),
    .buf_wsel (buf_wsel),
    .buf_rsel (buf_rsel),
    .buf_rrow (buf_rrow),
    .fil_size (fil_size),
    .col_data (col_data)
  );

  window_shift u_shift (
    .clk       (clk),
    .xrst      (xrst),
    .col_data  (col_data),
    .buf_start (buf_start),
    .buf_valid (buf_valid),
    .buf_stop  (buf_stop),
    .win_data  (win_data),
    .win_start (win_start),
    .win_valid (win_valid),
    .win_stop  (win_stop)
  );

endmodule

// ==== testbench/linebuf_tb.sv ====
module linebuf_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period  = 40;
  localparam int drive_delay = 2;
  localparam int model_size  = linebuf_pkg::buf_size;

  logic                clk;
  logic                xrst;
  linebuf_pkg::len_t   img_size;
  linebuf_pkg::len_t   fil_size;
  linebuf_pkg::len_t   pad_size;
  logic                buf_req;
  logic                buf_ack;
  logic                pix_ready;
  linebuf_pkg::pixel_t pix_data;
  logic                win_start;
  logic                win_valid;
  logic                win_stop;
  linebuf_pkg::pixel_t win_data [linebuf_pkg::max_fil][linebuf_pkg::max_fil];

  linebuf_pkg::pixel_t padded [model_size][model_size];   // padded image of the current frame
  integer              seed;

  linebuf_top dut (
    .clk       (clk),
    .xrst      (xrst),
    .img_size  (img_size),
    .fil_size  (fil_size),
    .pad_size  (pad_size),
    .buf_req   (buf_req),
    .buf_ack   (buf_ack),
    .pix_ready (pix_ready),
    .pix_data  (pix_data),
    .win_start (win_start),
    .win_valid (win_valid),
    .win_stop  (win_stop),
    .win_data  (win_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_on_error(input string what);
    $display("error: %s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on an error");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic wait_for_ack(input int limit);
    int cycles;
    cycles = 0;
    while (buf_ack !== 1'b1) begin
      if (cycles >= limit) begin
        stop_on_error("timeout while waiting for buf_ack to rise");
      end
      next_cycle();
      cycles++;
    end
  endtask

  // zeros all around, random pixels inside the img x img area
  task automatic build_padded_image(input int img, input int pad);
    for (int r = 0; r < model_size; r++) begin
      for (int c = 0; c < model_size; c++) begin
        padded[r][c] = '0;
      end
    end
    for (int r = 0; r < img; r++) begin
      for (int c = 0; c < img; c++) begin
        padded[r+pad][c+pad] = linebuf_pkg::pixel_t'($random(seed));
      end
    end
  endtask

  task automatic check_window(input int k, input int img, input int fil, input int pad);
    int n;
    int r;
    int c;
    int col;
    n = img + 2 * pad - fil + 1;
    r = k / n;
    c = k % n;
    for (int i = 0; i < fil; i++) begin
      for (int m = 0; m < fil; m++) begin
        col = linebuf_pkg::max_fil - 1 - m;   // newest column sits at the top index
        check_value($sformatf("win_data[%0d][%0d] of window %0d", i, col, k),
                    win_data[i][col], padded[r+i][c+fil-1-m]);
      end
    end
  endtask

  // one whole frame, from the request until buf_ack returns
  task automatic run_frame(input int img, input int fil, input int pad);
    int   n;
    int   total;
    int   wins;
    int   pixels;
    int   cycles;
    int   limit;
    logic done;
    n      = img + 2 * pad - fil + 1;
    total  = n * n;
    limit  = 4 * (img + 2 * pad + 2) * (img + 2 * pad + 2) + 100;
    wins   = 0;
    pixels = 0;
    cycles = 0;
    done   = 1'b0;
    build_padded_image(img, pad);
    wait_for_ack(10);
    img_size = linebuf_pkg::len_t'(img);
    fil_size = linebuf_pkg::len_t'(fil);
    pad_size = linebuf_pkg::len_t'(pad);
    buf_req  = 1'b1;
    next_cycle();
    buf_req  = 1'b0;
    while (!done) begin
      if (cycles >= limit) begin
        stop_on_error("timeout while waiting for buf_ack to return after the frame");
      end
      if (win_valid === 1'b1) begin
        if (wins >= total) begin
          stop_on_error("more windows arrived than the frame holds");
        end
        check_window(wins, img, fil, pad);
        check_value("win_start", win_start, wins == 0);
        check_value("win_stop", win_stop, wins == total - 1);
        wins++;
      end else begin
        check_value("win_start", win_start, 0);
        check_value("win_stop", win_stop, 0);
      end
      done = buf_ack === 1'b1;   // ack may return with the last window
      if (pix_ready === 1'b1) begin
        if (pixels < img * img) begin
          pix_data = padded[pixels/img+pad][pixels%img+pad];
        end else begin
          pix_data = '0;
        end
        pixels++;
      end
      next_cycle();
      cycles++;
    end
    check_value("window count", wins, total);
    check_value("pix_ready cycles", pixels, img * img);
  endtask

  task automatic reset_outputs_low();
    check_value("buf_ack", buf_ack, 0);
    check_value("pix_ready", pix_ready, 0);
    check_value("win_valid", win_valid, 0);
    check_value("win_start", win_start, 0);
    check_value("win_stop", win_stop, 0);
    wait_for_ack(10);
  endtask

  task automatic filter3_with_pad1();
    run_frame(8, 3, 1);
  endtask

  task automatic filter5_without_pad();
    run_frame(12, 5, 0);
  endtask

  task automatic filter5_full_pad();
    run_frame(linebuf_pkg::max_img, 5, 2);
  endtask

  task automatic two_frames_back_to_back();
    run_frame(6, 3, 0);
    run_frame(10, 5, 1);
  endtask

  initial begin
    seed     = 32'h0302_321c;
    xrst     = 1'b0;
    img_size = '0;
    fil_size = '0;
    pad_size = '0;
    buf_req  = 1'b0;
    pix_data = '0;
    repeat (3) @(posedge clk);
    #drive_delay;
    xrst = 1'b1;
    reset_outputs_low();
    filter3_with_pad1();
    filter5_without_pad();
    filter5_full_pad();
    two_frames_back_to_back();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
logic/linebuf_pkg.sv
logic/line_mem.sv
logic/linebuf_ctrl.sv
logic/linebuf_bank.sv
logic/window_shift.sv
logic/linebuf_top.sv
testbench/linebuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the line buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  -f src.f --top-module linebuf_tb -o linebuf_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/linebuf_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0
